//--- sources.f
design/adpcm_cfg_pkg.sv
design/adpcm_rom_pkg.sv
design/adpcm_timing.sv
design/adpcm_decode.sv
design/adpcm_acc.sv
design/adpcm_mix_top.sv
sim/adpcm_mix_assertions.sv
sim/tb_adpcm_mix.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the ADPCM-A mixer testbench with Verilator
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_adpcm_mix -f sources.f \
    --Mdir obj_dir -o tb_adpcm_mix
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_adpcm_mix > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "sim failed" "$log"; then
    exit 1
fi
exit 0

//--- sim/tb_adpcm_mix.sv
/* testbench for the ADPCM-A mixer top, random nibbles from a fixed-seed xorshift,
   checked against a slot-level model of decode, round sums and interpolation */
`timescale 1ns/1ps

module tb_adpcm_mix;

    localparam int num_rounds = 320;                    // five phases of 64 rounds
    localparam int clk_ns     = 8;
    localparam int round_clks = adpcm_cfg_pkg::num_ch * adpcm_cfg_pkg::cen_div;
    localparam int wd_ns      = (16 + (num_rounds + 2) * round_clks + 400) * clk_ns;
    localparam int step_table [49] = '{16, 17, 19, 21, 23, 25, 28, 31, 34, 37, 41, 45,
        50, 55, 60, 66, 73, 80, 88, 97, 107, 118, 130, 143, 157, 173, 190, 209, 230,
        253, 279, 307, 337, 371, 408, 449, 494, 544, 598, 658, 724, 796, 876, 963,
        1060, 1166, 1282, 1411, 1552};
    localparam int adj_table [8] = '{-1, -1, -1, -1, 2, 5, 7, 9};

    logic                       clk;
    logic                       rst_n;
    adpcm_cfg_pkg::nibble_set_t nibbles;
    adpcm_cfg_pkg::chan_ctrl_t  ctrl;
    adpcm_cfg_pkg::stereo_t     audio;
    logic                       sample_valid;
    logic                       nib_req;

    logic [31:0]                rng;
    adpcm_cfg_pkg::nibble_set_t cur_nib;                // set decoded in the current round
    adpcm_cfg_pkg::chan_ctrl_t  cur_ctrl;
    int                         m_sig [6];              // model predictor state
    int                         m_idx [6];
    logic [35:0]                sum_q [$];              // finished round sums {left, right}
    logic signed [17:0]         m_last [2];             // per side, 0 left 1 right
    logic signed [17:0]         m_step [2];
    logic signed [17:0]         m_full [2];             // interpolated, before saturation
    int                         ev_phase;
    int                         rounds_done;
    int                         cyc;
    int                         last_req;
    int                         sv_cnt;

    adpcm_mix_top u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .nibbles      (nibbles),
        .ctrl         (ctrl),
        .audio        (audio),
        .sample_valid (sample_valid),
        .nib_req      (nib_req)
    );

    bind adpcm_mix_top adpcm_mix_assertions u_assert (.clk(clk), .rst_n(rst_n), .ch(ch),
        .cen111(cen111), .cen55(cen55), .sample_valid(sample_valid), .nib_req(nib_req));

    always #(clk_ns / 2) clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [15:0] sat16(input logic signed [17:0] v);
        if (v > 18'sd32767)
            return 16'h7fff;
        if (v < -18'sd32768)
            return 16'h8000;
        return v[15:0];
    endfunction

    function automatic logic signed [17:0] interp_step(input logic signed [17:0] d);
        logic signed [22:0] p;
        p = 23'(d) * 23'sd43;                           // 43/128 of the round difference
        return 18'(p >>> 7);
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "run aborted");
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] expv);
        if (got !== expv) begin
            $display("MISMATCH %s got=%h expected=%h", name, got, expv);
            $display("sim failed");
            $fatal(1, "value check");
        end
    endtask

    task automatic decode_round;
        int mag;
        int diff;
        int pcm;
        int tot_l;
        int tot_r;
        tot_l = 0;
        tot_r = 0;
        for (int i = 0; i < adpcm_cfg_pkg::num_ch; i++) begin
            pcm = 0;
            if (!cur_ctrl.key_on[i]) begin
                m_sig[i] = 0;                           // keyed off restarts at index 0
                m_idx[i] = 0;
            end else begin
                mag      = int'(cur_nib.nib[i][2:0]);
                diff     = ((2 * mag + 1) * step_table[m_idx[i]]) / 8;
                m_sig[i] = cur_nib.nib[i][3] ? m_sig[i] - diff : m_sig[i] + diff;
                m_sig[i] = (m_sig[i] > 2047) ? 2047 : (m_sig[i] < -2048) ? -2048 : m_sig[i];
                m_idx[i] = m_idx[i] + adj_table[mag];
                m_idx[i] = (m_idx[i] > 48) ? 48 : (m_idx[i] < 0) ? 0 : m_idx[i];
                pcm      = m_sig[i] * 16;
            end
            if (cur_ctrl.pan[i][1])
                tot_l += pcm;
            if (cur_ctrl.pan[i][0])
                tot_r += pcm;
        end
        sum_q.push_back({18'(tot_l), 18'(tot_r)});      // sums wrap at 18 bits
    endtask

    task automatic output_event;
        logic [35:0]        fin;
        logic signed [17:0] fsum;
        logic signed [17:0] held;
        logic [15:0]        expv [2];
        for (int s = 0; s < 2; s++)
            expv[s] = sat16(m_full[s]);                 // output lags by one strobe
        if (ev_phase == 0 && sum_q.size() == 0) begin
            fail_run("no finished round sum available at the first strobe of a round");
        end else begin
            if (ev_phase == 0) begin
                fin = sum_q.pop_front();
                for (int s = 0; s < 2; s++) begin
                    fsum      = (s == 0) ? fin[35:18] : fin[17:0];
                    held      = m_last[s];
                    m_step[s] = interp_step(fsum - m_last[s]);
                    m_last[s] = fsum;
                    m_full[s] = held;                   // restart from the older sum
                end
            end else begin
                for (int s = 0; s < 2; s++)
                    m_full[s] = m_full[s] + m_step[s];
            end
            ev_phase = (ev_phase == 2) ? 0 : ev_phase + 1;
            if (rounds_done < 64)                       // both sides panned in phase 0
                check_val("audio.right vs left", {16'h0, audio.right}, {16'h0, audio.left});
            check_val("audio.left", {16'h0, audio.left}, {16'h0, expv[0]});
            check_val("audio.right", {16'h0, audio.right}, {16'h0, expv[1]});
        end
    endtask

    task automatic next_stimulus;
        int phase;
        phase = rounds_done / 64;
        rng   = xorshift32(rng);
        if (phase == 2)
            cur_nib = 24'h777777;                       // max positive, drives saturation
        else if (phase == 3)
            cur_nib = 24'hffffff;                       // max negative
        else
            cur_nib = rng[23:0];
        if (rounds_done % 64 == 0) begin
            rng             = xorshift32(rng);
            cur_ctrl.pan    = rng[11:0];
            cur_ctrl.key_on = (phase == 2 || phase == 3) ? 6'h3f : rng[17:12];
        end
        nibbles <= cur_nib;
        ctrl    <= cur_ctrl;
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            cyc = cyc + 1;
            if (cyc <= 2 * adpcm_cfg_pkg::cen_div) begin   // before the first cen55
                check_val("sample_valid", 32'(sample_valid), 32'd0);
                check_val("nib_req", 32'(nib_req), 32'd0);
                check_val("audio", audio, 32'd0);
            end
            if (sample_valid) begin
                sv_cnt = sv_cnt + 1;
                output_event();
            end
            if (nib_req) begin
                if (rounds_done > 0)
                    check_val("nib_req period", 32'(cyc - last_req), 32'(round_clks));
                check_val("sample_valid per round", 32'(sv_cnt), 32'd3);
                sv_cnt      = 0;
                last_req    = cyc;
                decode_round();
                rounds_done = rounds_done + 1;
                next_stimulus();
            end
        end
    end

    initial begin
        #(wd_ns);
        fail_run("watchdog timeout, the DUT did not finish all rounds in time");
    end

    initial begin
        clk             = 1'b0;
        rst_n           = 1'b0;
        rng             = xorshift32(32'he07cb689);
        cur_nib         = rng[23:0];
        cur_ctrl.key_on = 6'h3f;                        // all channels on, both sides
        cur_ctrl.pan    = 12'hfff;
        nibbles         = cur_nib;
        ctrl            = cur_ctrl;
        for (int s = 0; s < 2; s++) begin
            m_last[s] = '0;
            m_step[s] = '0;
            m_full[s] = '0;
        end
        sum_q.push_back('0);                            // accumulator holds zero out of reset
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        wait (rounds_done >= num_rounds);
        @(posedge clk);
        $display("sim passed");
        $finish;
    end

endmodule

//--- sim/adpcm_mix_assertions.sv
/* concurrent checks on the mixer top, bound into adpcm_mix_top by the testbench */
`timescale 1ns/1ps

module adpcm_mix_assertions (
    input logic               clk,
    input logic               rst_n,
    input adpcm_cfg_pkg::ch_t ch,
    input logic               cen111,
    input logic               cen55,
    input logic               sample_valid,
    input logic               nib_req
);

    ch_range: assert property (@(posedge clk) disable iff (!rst_n)
        ch <= 3'(adpcm_cfg_pkg::num_ch - 1))
        else $error("channel counter past the last channel");

    valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        sample_valid |=> !sample_valid)
        else $error("sample_valid high for more than one clock");

    req_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        nib_req |=> !nib_req)
        else $error("nib_req high for more than one clock");

    // output strobe is a subset of the slot strobe
    cen_nest: assert property (@(posedge clk) disable iff (!rst_n) cen55 |-> cen111)
        else $error("cen55 without cen111");

endmodule

//--- design/adpcm_mix_top.sv
/* six-channel ADPCM-A mixer top, timing, shared decoder and one
   accumulator per side, stereo output with a sample valid pulse */
`timescale 1ns/1ps

module adpcm_mix_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  adpcm_cfg_pkg::nibble_set_t nibbles,
    input  adpcm_cfg_pkg::chan_ctrl_t  ctrl,
    output adpcm_cfg_pkg::stereo_t     audio,
    output logic                       sample_valid,
    output logic                       nib_req
);

    logic                 cen111;            // slot strobe
    logic                 cen55;             // output strobe
    adpcm_cfg_pkg::ch_t   ch;
    adpcm_cfg_pkg::slot_t slot;              // decoded sample, one slot behind ch

    adpcm_timing u_timing (
        .clk    (clk),
        .rst_n  (rst_n),
        .cen111 (cen111),
        .cen55  (cen55),
        .ch     (ch)
    );

    adpcm_decode u_decode (
        .clk     (clk),
        .rst_n   (rst_n),
        .cen111  (cen111),
        .ch      (ch),
        .nibbles (nibbles),
        .ctrl    (ctrl),
        .slot    (slot),
        .nib_req (nib_req)
    );

    adpcm_acc u_acc_l (
        .clk     (clk),
        .rst_n   (rst_n),
        .cen111  (cen111),
        .cen55   (cen55),
        .ch      (slot.ch),
        .pcm_in  (slot.pcm_l),
        .pcm_out (audio.left)
    );

    adpcm_acc u_acc_r (
        .clk     (clk),
        .rst_n   (rst_n),
        .cen111  (cen111),
        .cen55   (cen55),
        .ch      (slot.ch),
        .pcm_in  (slot.pcm_r),
        .pcm_out (audio.right)
    );

    // audio loads on cen55, valid the cycle after
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= cen55;
        end
    end

endmodule

//--- design/adpcm_acc.sv
/* sums the six channel slots of one side and raises the rate from
   18.5 kHz to 55.5 kHz by linear interpolation, saturating to 16 bits */
`timescale 1ns/1ps

module adpcm_acc (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cen111,
    input  logic               cen55,
    input  adpcm_cfg_pkg::ch_t ch,
    input  logic signed [15:0] pcm_in,       // one channel per slot
    output logic signed [15:0] pcm_out       // 55.5 kHz stream
);

    logic signed [17:0] pcm_wide;
    logic signed [17:0] acc;                 // running sum of this round
    logic signed [17:0] last;                // finished sum of last round
    logic signed [17:0] step;                // interpolation increment
    logic signed [17:0] pcm_full;            // interpolated value, pre-saturation
    logic signed [17:0] diff;
    logic signed [22:0] diff_ext;
    logic signed [22:0] step_full;           // diff * 43
    logic signed [22:0] step_shr;
    logic               first;
    logic               ovf;

    assign first    = (ch == '0);
    assign pcm_wide = {{2{pcm_in[15]}}, pcm_in};

    // 43/128 = 1/4 + 1/16 + 1/64 + 1/128
    assign diff      = acc - last;
    assign diff_ext  = {{5{diff[17]}}, diff};
    assign step_full = diff_ext + (diff_ext <<< 1) + (diff_ext <<< 3) + (diff_ext <<< 5);
    assign step_shr  = step_full >>> 7;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc  <= '0;
            last <= '0;
            step <= '0;
        end else if (cen111) begin
            acc <= first ? pcm_wide : acc + pcm_wide;   // restart at channel 0
            if (first) begin
                last <= acc;
                step <= step_shr[17:0];
            end
        end
    end

    // top three bits must agree to fit 16 bits
    assign ovf = (pcm_full[17:15] != 3'b000) && (pcm_full[17:15] != 3'b111);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pcm_full <= '0;
            pcm_out  <= '0;
        end else if (cen55) begin
            pcm_full <= first ? last : pcm_full + step;
            if (ovf) begin
                pcm_out <= pcm_full[17] ? 16'sh8000 : 16'sh7fff;
            end else begin
                pcm_out <= pcm_full[15:0];
            end
        end
    end

endmodule

//--- design/adpcm_decode.sv
/* ADPCM-A predictor shared by the six channels in time slots; one nibble
   per channel per round, key-on reset and left/right pan on the output */
`timescale 1ns/1ps

module adpcm_decode (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       cen111,
    input  adpcm_cfg_pkg::ch_t         ch,
    input  adpcm_cfg_pkg::nibble_set_t nibbles,
    input  adpcm_cfg_pkg::chan_ctrl_t  ctrl,
    output adpcm_cfg_pkg::slot_t       slot,
    output logic                       nib_req
);

    logic signed [11:0] sig_q [adpcm_cfg_pkg::num_ch];  // predictor signal
    logic        [5:0]  idx_q [adpcm_cfg_pkg::num_ch];  // step table index

    adpcm_cfg_pkg::phase_t phase;

    logic [3:0]         nib;
    logic               key;
    logic [1:0]         pan;
    logic signed [11:0] sig_cur;
    logic [5:0]         idx_cur;
    logic [10:0]        step;
    logic [14:0]        prod;       // (2*mag+1)*step, max 23280
    logic [11:0]        diff;       // prod/8, max 2910
    logic signed [13:0] sig_sum;    // before clamp
    logic signed [11:0] sig_nxt;
    logic signed [4:0]  adj;
    logic signed [6:0]  idx_sum;
    logic [5:0]         idx_nxt;
    logic signed [15:0] pcm;

    assign phase   = cen111 ? adpcm_cfg_pkg::update : adpcm_cfg_pkg::idle;

    // current channel's inputs and state
    assign nib     = nibbles.nib[ch];
    assign key     = ctrl.key_on[ch];
    assign pan     = ctrl.pan[ch];
    assign sig_cur = sig_q[ch];
    assign idx_cur = idx_q[ch];

    assign step = adpcm_rom_pkg::step_size(idx_cur);
    assign prod = 15'({nib[2:0], 1'b1}) * 15'(step);
    assign diff = prod[14:3];                           // truncated
    assign adj  = adpcm_rom_pkg::index_adj(nib[2:0]);

    always_comb begin
        if (nib[3]) begin
            sig_sum = $signed({{2{sig_cur[11]}}, sig_cur}) - $signed({2'b00, diff});
        end else begin
            sig_sum = $signed({{2{sig_cur[11]}}, sig_cur}) + $signed({2'b00, diff});
        end
        if (sig_sum > 14'sd2047) begin
            sig_nxt = 12'sd2047;                        // clamp high
        end else if (sig_sum < -14'sd2048) begin
            sig_nxt = -12'sd2048;                       // clamp low
        end else begin
            sig_nxt = sig_sum[11:0];
        end

        idx_sum = $signed({1'b0, idx_cur}) + $signed({{2{adj[4]}}, adj});
        if (idx_sum < 7'sd0) begin
            idx_nxt = 6'd0;
        end else if (idx_sum > 7'sd48) begin
            idx_nxt = 6'd48;                            // top of step table
        end else begin
            idx_nxt = idx_sum[5:0];
        end

        pcm = key ? {sig_nxt, 4'b0000} : 16'sd0;        // keyed off is silent
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < adpcm_cfg_pkg::num_ch; i++) begin
                sig_q[i] <= '0;
                idx_q[i] <= '0;
            end
            slot    <= '0;
            nib_req <= 1'b0;
        end else begin
            // channel 5 sampled, source may load the next set
            nib_req <= (phase == adpcm_cfg_pkg::update) &&
                       (ch == 3'(adpcm_cfg_pkg::num_ch - 1));
            if (phase == adpcm_cfg_pkg::update) begin
                sig_q[ch]  <= key ? sig_nxt : '0;       // key off restarts predictor
                idx_q[ch]  <= key ? idx_nxt : '0;
                slot.ch    <= ch;
                slot.pcm_l <= pan[1] ? pcm : 16'sd0;
                slot.pcm_r <= pan[0] ? pcm : 16'sd0;
            end
        end
    end

endmodule

//--- design/adpcm_timing.sv
/* clock-enable generator, slot strobe every cen_div clocks, output strobe
   on every second slot, plus the channel slot counter */
`timescale 1ns/1ps

module adpcm_timing (
    input  logic               clk,
    input  logic               rst_n,
    output logic               cen111,
    output logic               cen55,
    output adpcm_cfg_pkg::ch_t ch
);

    logic [adpcm_cfg_pkg::cen_cnt_w-1:0] cnt;    // clock divider
    logic                                tog;    // halves the slot rate
    logic                                wrap;

    assign wrap = (cnt == adpcm_cfg_pkg::cen_cnt_w'(adpcm_cfg_pkg::cen_div - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt    <= '0;
            tog    <= 1'b0;
            cen111 <= 1'b0;
            cen55  <= 1'b0;
            ch     <= '0;
        end else begin
            cnt    <= wrap ? '0 : cnt + 1'b1;
            cen111 <= wrap;                      // first pulse cen_div clocks after reset
            // odd slots, so slot.ch is 0, 2, 4 at the accumulators
            cen55  <= wrap & tog;
            if (wrap) begin
                tog <= ~tog;
            end
            if (cen111) begin
                ch <= (ch == 3'(adpcm_cfg_pkg::num_ch - 1)) ? '0 : ch + 1'b1;
            end
        end
    end

endmodule

//--- design/adpcm_rom_pkg.sv
/* ADPCM-A step-size and index-adjust tables, wrapped in lookup functions
   used by the decoder */
package adpcm_rom_pkg;

    localparam int step_cnt = 49;                 // entries in the step table

    // standard ADPCM-A step sizes, index 0..48
    localparam logic [10:0] step_tab [step_cnt] = '{
        11'd16,   11'd17,   11'd19,   11'd21,   11'd23,   11'd25,   11'd28,
        11'd31,   11'd34,   11'd37,   11'd41,   11'd45,   11'd50,   11'd55,
        11'd60,   11'd66,   11'd73,   11'd80,   11'd88,   11'd97,   11'd107,
        11'd118,  11'd130,  11'd143,  11'd157,  11'd173,  11'd190,  11'd209,
        11'd230,  11'd253,  11'd279,  11'd307,  11'd337,  11'd371,  11'd408,
        11'd449,  11'd494,  11'd544,  11'd598,  11'd658,  11'd724,  11'd796,
        11'd876,  11'd963,  11'd1060, 11'd1166, 11'd1282, 11'd1411, 11'd1552
    };

    function automatic logic [10:0] step_size(input logic [5:0] idx);
        // indexes past the table end stick at the last step
        if (idx > 6'(step_cnt - 1)) begin
            return step_tab[step_cnt-1];
        end
        return step_tab[idx];
    endfunction

    // index change from the nibble magnitude
    function automatic logic signed [4:0] index_adj(input logic [2:0] mag);
        logic signed [4:0] adj;
        case (mag)
            3'd4:    adj = 5'sd2;
            3'd5:    adj = 5'sd5;
            3'd6:    adj = 5'sd7;
            3'd7:    adj = 5'sd9;
            default: adj = -5'sd1;                // small magnitudes shrink the step
        endcase
        return adj;
    endfunction

endpackage

//--- design/adpcm_cfg_pkg.sv
/* timing constants and shared types of the six-channel ADPCM-A mixer
   referenced by scoped name from the design and the testbench */
package adpcm_cfg_pkg;

    localparam int num_ch    = 6;                 // ADPCM-A channels
    localparam int cen_div   = 8;                 // clocks per slot strobe
    localparam int cen_cnt_w = $clog2(cen_div);   // divider counter width

    typedef logic [2:0] ch_t;                     // channel number 0..5

    // one nibble per channel per round, channel 0 in nib[0]
    typedef struct packed {
        logic [num_ch-1:0][3:0] nib;              // bit 3 sign, 2:0 magnitude
    } nibble_set_t;

    typedef struct packed {
        logic [num_ch-1:0]      key_on;           // 0 holds channel in reset
        logic [num_ch-1:0][1:0] pan;              // [1] left enable, [0] right enable
    } chan_ctrl_t;

    // decoded sample of one slot, decoder to accumulators
    typedef struct packed {
        ch_t                ch;                   // channel this sample came from
        logic signed [15:0] pcm_l;                // zero when not panned left
        logic signed [15:0] pcm_r;                // zero when not panned right
    } slot_t;

    typedef struct packed {
        logic signed [15:0] left;
        logic signed [15:0] right;
    } stereo_t;

    // decoder slot phase
    typedef enum logic {
        idle   = 1'b0,                            // hold state
        update = 1'b1                             // apply current nibble
    } phase_t;

endpackage
